/* common/sssp_pkg.sv */
package sssp_pkg;

localparam int N_THREADS  = 4;
localparam int N_TAGS     = 8;
localparam int LINE_WORDS = 8;  // 64-bit edge records per memory line
localparam int LINE_BITS  = LINE_WORDS * 64;

localparam int WORD_IDX_W = $clog2(LINE_WORDS);
localparam int LINE_OFS_W = WORD_IDX_W + 3;  // byte offset bits inside a line

typedef logic [$clog2(N_THREADS)-1:0] thread_id_t;
typedef logic [$clog2(N_TAGS)-1:0]    tag_t;
typedef logic [WORD_IDX_W-1:0]        word_idx_t;
typedef logic [WORD_IDX_W:0]          word_cnt_t;  // 0..LINE_WORDS

typedef struct packed {
   logic [31:0] ts;
   logic [31:0] locale;
} task_t;

typedef struct packed {
   task_t       task_desc;
   logic [15:0] eo_begin;
   logic [15:0] eo_end;  // exclusive
} edge_task_t;

typedef struct packed {
   logic [31:0] addr;     // byte address of the first edge
   logic [15:0] n_words;
} burst_req_t;

// what a tag expects back from memory
typedef struct packed {
   thread_id_t thread;
   word_idx_t  first;
   word_cnt_t  count;
} line_rec_t;

typedef struct packed {
   thread_id_t  thread;
   logic [63:0] data;  // weight in [63:32], neighbor in [31:0]
   logic        last;
} edge_word_t;

endpackage

/* hw/free_list.sv */
`timescale 1ns/1ps

module free_list #(
   parameter type ENTRY_T = logic [1:0],
   parameter int  DEPTH   = 4
) (
   input  logic   clk,
   input  logic   rstn,
   input  logic   put_valid,
   input  ENTRY_T put_id,
   input  logic   take,
   output ENTRY_T next_id,
   output logic   empty,
   output logic   full
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

ENTRY_T             ids [DEPTH];
logic [PTR_W-1:0]   rd_ptr;
logic [PTR_W-1:0]   wr_ptr;
logic [CNT_W-1:0]   count;

assign next_id = ids[rd_ptr];
assign empty   = (count == '0);
assign full    = (count == CNT_W'(DEPTH));

always_ff @(posedge clk) begin
   if (!rstn) begin
      for (int i = 0; i < DEPTH; i++) begin
         ids[i] <= ENTRY_T'(i);  // pool starts with every id
      end
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= CNT_W'(DEPTH);
   end else begin
      if (put_valid) begin
         ids[wr_ptr] <= put_id;
         wr_ptr      <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (take) begin
         rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(put_valid) - CNT_W'(take);
   end
end

endmodule

/* hw/edge_addr_gen.sv */
`timescale 1ns/1ps

module edge_addr_gen import sssp_pkg::*; #(
   parameter logic [31:0] EDGE_BASE = 32'h0010_0000
) (
   input  edge_task_t in_task,
   output burst_req_t req,
   output logic       has_edges
);

logic [31:0] byte_ofs;
logic [15:0] n_edges;

// each edge record is one 64-bit word
assign byte_ofs = {13'd0, in_task.eo_begin, 3'b000};
assign n_edges  = in_task.eo_end - in_task.eo_begin;

always_comb begin
   req.addr    = EDGE_BASE + byte_ofs;
   req.n_words = n_edges;
end

assign has_edges = (n_edges != 16'd0);  // leaf vertex, nothing to read

endmodule

/* hw/thread_ctrl.sv */
`timescale 1ns/1ps

module thread_ctrl import sssp_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       in_valid,
   output logic       in_ready,
   input  edge_task_t in_task,
   input  burst_req_t req_in,
   input  logic       has_edges,

   output logic       req_valid,
   input  logic       req_ready,
   output burst_req_t req_out,
   output thread_id_t req_thread,

   input  logic       word_fire,
   input  thread_id_t word_thread,
   output logic       word_last,
   output task_t      parent,

   output logic       idle
);

task_t       parent_mem [N_THREADS];
logic [15:0] remaining [N_THREADS];  // edges still owed per thread
thread_id_t  free_thread;
logic        no_thread;
logic        grant;
logic        thread_done;

assign req_valid  = in_valid & has_edges & !no_thread;
assign in_ready   = has_edges ? (!no_thread & req_ready) : 1'b1;  // edgeless tasks just vanish
assign grant      = req_valid & req_ready;
assign req_out    = req_in;
assign req_thread = free_thread;

assign parent      = parent_mem[word_thread];
assign word_last   = (remaining[word_thread] == 16'd1);
assign thread_done = word_fire & word_last;

always_ff @(posedge clk) begin
   if (!rstn) begin
      for (int i = 0; i < N_THREADS; i++) begin
         remaining[i] <= '0;
      end
   end else begin
      if (grant) remaining[free_thread] <= req_in.n_words;
      // a thread cannot be granted while its words are still flowing
      if (word_fire) remaining[word_thread] <= remaining[word_thread] - 16'd1;
   end
end

always_ff @(posedge clk) begin
   if (grant) parent_mem[free_thread] <= in_task.task_desc;
end

free_list #(
   .ENTRY_T (thread_id_t),
   .DEPTH   (N_THREADS)
) u_thread_list (
   .clk       (clk),
   .rstn      (rstn),
   .put_valid (thread_done),
   .put_id    (word_thread),
   .take      (grant),
   .next_id   (free_thread),
   .empty     (no_thread),
   .full      (idle)  // every thread back home
);

endmodule

/* read_engine/read_issuer.sv */
`timescale 1ns/1ps

module read_issuer import sssp_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  logic        req_valid,
   output logic        req_ready,
   input  burst_req_t  req,
   input  thread_id_t  req_thread,

   output logic        arvalid,
   input  logic        arready,
   output logic [31:0] araddr,
   output tag_t        arid,

   input  logic        ret_valid,
   input  tag_t        ret_tag,

   input  tag_t        lookup_tag,
   output line_rec_t   lookup_rec
);

logic        busy;
logic [31:0] cur_addr;
logic [15:0] cur_n;
thread_id_t  cur_thread;
word_idx_t   first;
word_cnt_t   room;
word_cnt_t   line_n;
logic        last_line;
logic        ar_fire;
logic        req_fire;
logic        tag_empty;
tag_t        free_tag;
line_rec_t   rec_table [N_TAGS];

assign first     = cur_addr[LINE_OFS_W-1:3];
assign room      = word_cnt_t'(LINE_WORDS) - word_cnt_t'(first);  // words up to line end
assign last_line = (cur_n <= 16'(room));
assign line_n    = last_line ? cur_n[WORD_IDX_W:0] : room;

// no read goes out without a tag to track it
assign arvalid = busy & !tag_empty;
assign araddr  = {cur_addr[31:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
assign arid    = free_tag;
assign ar_fire = arvalid & arready;

assign req_ready = !busy | (ar_fire & last_line);
assign req_fire  = req_valid & req_ready;

always_ff @(posedge clk) begin
   if (!rstn) begin
      busy <= 1'b0;
   end else if (req_fire) begin
      busy <= 1'b1;
   end else if (ar_fire & last_line) begin
      busy <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (req_fire) begin
      cur_addr   <= req.addr;
      cur_n      <= req.n_words;
      cur_thread <= req_thread;
   end else if (ar_fire) begin
      cur_addr <= araddr + 32'(LINE_WORDS * 8);  // next line starts at word 0
      cur_n    <= cur_n - 16'(line_n);
   end
end

always_ff @(posedge clk) begin
   if (ar_fire) begin
      rec_table[free_tag] <= '{thread: cur_thread, first: first, count: line_n};
   end
end

assign lookup_rec = rec_table[lookup_tag];

free_list #(
   .ENTRY_T (tag_t),
   .DEPTH   (N_TAGS)
) u_tag_list (
   .clk       (clk),
   .rstn      (rstn),
   .put_valid (ret_valid),
   .put_id    (ret_tag),
   .take      (ar_fire),
   .next_id   (free_tag),
   .empty     (tag_empty),
   .full      ()
);

endmodule

/* read_engine/line_unpacker.sv */
`timescale 1ns/1ps

module line_unpacker import sssp_pkg::*; (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 rvalid,
   output logic                 rready,
   input  tag_t                 rid,
   input  logic [LINE_BITS-1:0] rdata,

   output tag_t                 lookup_tag,
   input  line_rec_t            lookup_rec,

   output logic                 ret_valid,
   output tag_t                 ret_tag,

   output logic                 word_valid,
   input  logic                 word_ready,
   output edge_word_t           word
);

logic                 held;   // a line sits in the buffer
logic [LINE_BITS-1:0] line_q;
line_rec_t            cur;    // first = next word, count = words left
logic                 r_fire;
logic                 w_fire;

assign rready     = !held;
assign r_fire     = rvalid & rready;
assign lookup_tag = rid;

// the record is captured with the line, so the tag can go back at once
assign ret_valid = r_fire;
assign ret_tag   = rid;

assign word_valid = held;
assign w_fire     = word_valid & word_ready;

always_comb begin
   word.thread = cur.thread;
   word.data   = line_q[cur.first*64 +: 64];
   word.last   = 1'b0;  // thread_ctrl knows the real burst end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      held <= 1'b0;
   end else if (r_fire) begin
      held <= 1'b1;
   end else if (w_fire && cur.count == word_cnt_t'(1)) begin
      held <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (r_fire) begin
      line_q <= rdata;
      cur    <= lookup_rec;
   end else if (w_fire) begin
      cur.first <= cur.first + 1'b1;
      cur.count <= cur.count - 1'b1;
   end
end

endmodule

/* hw/child_gen.sv */
`timescale 1ns/1ps

module child_gen import sssp_pkg::*; (
   input  logic       clk,
   input  logic       rstn,

   input  logic       word_valid,
   output logic       word_ready,
   input  edge_word_t word,
   input  task_t      parent,

   output logic       out_valid,
   input  logic       out_ready,
   output task_t      out_task
);

assign word_ready = !out_valid | out_ready;

always_ff @(posedge clk) begin
   if (!rstn) begin
      out_valid <= 1'b0;
   end else if (word_valid & word_ready) begin
      out_valid <= 1'b1;
   end else if (out_ready) begin
      out_valid <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (word_valid & word_ready) begin
      out_task.ts     <= parent.ts + word.data[63:32];  // relax across the edge
      out_task.locale <= word.data[31:0];
   end
end

endmodule

/* hw/ro_stage_top.sv */
`timescale 1ns/1ps

module ro_stage_top import sssp_pkg::*; #(
   parameter logic [31:0] EDGE_BASE = 32'h0010_0000
) (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 in_valid,
   output logic                 in_ready,
   input  edge_task_t           in_task,

   output logic                 arvalid,
   input  logic                 arready,
   output logic [31:0]          araddr,
   output tag_t                 arid,

   input  logic                 rvalid,
   output logic                 rready,
   input  tag_t                 rid,
   input  logic [LINE_BITS-1:0] rdata,

   output logic                 out_valid,
   input  logic                 out_ready,
   output task_t                out_task,

   output logic                 idle
);

burst_req_t gen_req;
burst_req_t iss_req;
logic       has_edges;
logic       req_valid;
logic       req_ready;
thread_id_t req_thread;
logic       ret_valid;
tag_t       ret_tag;
tag_t       lookup_tag;
line_rec_t  lookup_rec;
logic       word_valid;
logic       word_ready;
logic       word_fire;
logic       word_last;
edge_word_t unp_word;
edge_word_t child_word;
task_t      parent;

assign word_fire  = word_valid & word_ready;
assign child_word = '{thread: unp_word.thread, data: unp_word.data, last: word_last};

edge_addr_gen #(.EDGE_BASE(EDGE_BASE)) u_edge_addr_gen (
   .in_task   (in_task),
   .req       (gen_req),
   .has_edges (has_edges)
);

thread_ctrl u_thread_ctrl (
   .clk         (clk),
   .rstn        (rstn),
   .in_valid    (in_valid),
   .in_ready    (in_ready),
   .in_task     (in_task),
   .req_in      (gen_req),
   .has_edges   (has_edges),
   .req_valid   (req_valid),
   .req_ready   (req_ready),
   .req_out     (iss_req),
   .req_thread  (req_thread),
   .word_fire   (word_fire),
   .word_thread (unp_word.thread),
   .word_last   (word_last),
   .parent      (parent),
   .idle        (idle)
);

read_issuer u_read_issuer (
   .clk        (clk),
   .rstn       (rstn),
   .req_valid  (req_valid),
   .req_ready  (req_ready),
   .req        (iss_req),
   .req_thread (req_thread),
   .arvalid    (arvalid),
   .arready    (arready),
   .araddr     (araddr),
   .arid       (arid),
   .ret_valid  (ret_valid),
   .ret_tag    (ret_tag),
   .lookup_tag (lookup_tag),
   .lookup_rec (lookup_rec)
);

line_unpacker u_line_unpacker (
   .clk        (clk),
   .rstn       (rstn),
   .rvalid     (rvalid),
   .rready     (rready),
   .rid        (rid),
   .rdata      (rdata),
   .lookup_tag (lookup_tag),
   .lookup_rec (lookup_rec),
   .ret_valid  (ret_valid),
   .ret_tag    (ret_tag),
   .word_valid (word_valid),
   .word_ready (word_ready),
   .word       (unp_word)
);

child_gen u_child_gen (
   .clk        (clk),
   .rstn       (rstn),
   .word_valid (word_valid),
   .word_ready (word_ready),
   .word       (child_word),
   .parent     (parent),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .out_task   (out_task)
);

endmodule

/* test/ro_stage_asserts.sv */
`timescale 1ns/1ps

module ro_stage_asserts import sssp_pkg::*; (
   input logic        clk,
   input logic        rstn,
   input logic        arvalid,
   input logic        arready,
   input logic [31:0] araddr,
   input tag_t        arid,
   input logic        rvalid,
   input logic        rready,
   input word_cnt_t   line_count,
   input logic        word_valid,
   input logic        word_ready
);

int        fail_count = 0;
word_cnt_t words_owed;  // words of the captured line not yet passed on

always_ff @(posedge clk) begin
   if (!rstn) begin
      words_owed <= '0;
   end else if (rvalid && rready) begin
      words_owed <= line_count;
   end else if (word_valid && word_ready && words_owed != '0) begin
      words_owed <= words_owed - 1'b1;
   end
end

// a read request may not change or vanish while it waits for arready
ar_hold: assert property (@(posedge clk) disable iff (!rstn)
   arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
   else begin
      fail_count++;
      $error("read address changed or dropped before arready");
   end

r_blocked: assert property (@(posedge clk) disable iff (!rstn) words_owed != '0 |-> !rready)
   else begin
      fail_count++;
      $error("rready high while words of the held line are still owed");
   end

endmodule

bind read_issuer ro_stage_asserts u_issuer_asserts (
   .clk        (clk),
   .rstn       (rstn),
   .arvalid    (arvalid),
   .arready    (arready),
   .araddr     (araddr),
   .arid       (arid),
   .rvalid     (1'b0),
   .rready     (1'b0),
   .line_count ('0),
   .word_valid (1'b0),
   .word_ready (1'b0)
);

bind line_unpacker ro_stage_asserts u_unpacker_asserts (
   .clk        (clk),
   .rstn       (rstn),
   .arvalid    (1'b0),  // AR side lives in the issuer
   .arready    (1'b0),
   .araddr     (32'h0),
   .arid       ('0),
   .rvalid     (rvalid),
   .rready     (rready),
   .line_count (lookup_rec.count),
   .word_valid (word_valid),
   .word_ready (word_ready)
);

/* test/ro_stage_checker.sv */
`timescale 1ns/1ps

module ro_stage_checker import sssp_pkg::*; (
   input  logic       clk,
   input  logic       rstn,
   input  logic       in_valid,
   input  logic       in_ready,
   input  edge_task_t in_task,
   input  logic       out_valid,
   input  logic       out_ready,
   input  task_t      out_task,
   input  logic       idle,
   output int         pending,
   output int         n_errors,
   output int         n_failed
);

task_t exp_q [$];
string cur_name;
int    test_errs;
int    n_children;

initial begin
   pending    = 0;
   n_errors   = 0;
   n_failed   = 0;
   test_errs  = 0;
   n_children = 0;
   cur_name   = "none";
end

// edge e: neighbor e, weight 3e+1 kept to 16 bits
function automatic task_t child_of(input task_t p, input int e);
   task_t       c;
   logic [15:0] weight;
   weight   = 16'(e * 3 + 1);
   c.ts     = p.ts + {16'h0, weight};
   c.locale = 32'(e);
   return c;
endfunction

task automatic count_error();
   test_errs++;
   n_errors++;
endtask

task automatic start_test(input string name);
   cur_name   = name;
   test_errs  = 0;
   n_children = 0;
endtask

task automatic finish_test();
   if (!idle) begin
      $display("test %s: idle is low after its last child was taken", cur_name);
      count_error();
   end
   if (test_errs == 0) begin
      $display("test %-14s ok, %0d children", cur_name, n_children);
   end else begin
      $display("test %-14s FAILED with %0d errors", cur_name, test_errs);
      n_failed++;
   end
endtask

always @(posedge clk) begin : monitor
   task_t exp;
   if (rstn) begin
      if (out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("test %s: child ts=%h locale=%h came out with none expected",
                     cur_name, out_task.ts, out_task.locale);
            count_error();
         end else begin
            exp = exp_q.pop_front();
            if (out_task !== exp) begin
               $display("** Error %s child %0d: expected ts=%h locale=%h, actual ts=%h locale=%h",
                        cur_name, n_children, exp.ts, exp.locale, out_task.ts, out_task.locale);
               count_error();
            end
            n_children++;
         end
      end
      if (in_valid && in_ready) begin
         for (int e = int'(in_task.eo_begin); e < int'(in_task.eo_end); e++) begin
            exp_q.push_back(child_of(in_task.task_desc, e));
         end
      end
      pending = exp_q.size();
   end
end

endmodule

/* test/ro_stage_tb.sv */
`timescale 1ns/1ps

module ro_stage_tb import sssp_pkg::*;;

localparam logic [31:0] EDGE_BASE = 32'h0010_0000;

typedef struct {
   string       name;
   logic [31:0] ts;
   logic [31:0] locale;
   logic [15:0] eo_begin;
   logic [15:0] eo_end;
   bit          rnd_ready;
   bit          last_of_test;  // drain and report after this row
} stim_row_t;

logic                 clk;
logic                 rstn;
logic                 in_valid;
logic                 in_ready;
edge_task_t           in_task;
logic                 arvalid;
logic                 arready;
logic [31:0]          araddr;
tag_t                 arid;
logic                 rvalid;
logic                 rready;
tag_t                 rid;
logic [LINE_BITS-1:0] rdata;
logic                 out_valid;
logic                 out_ready;
task_t                out_task;
logic                 idle;
logic                 ready_mode;
int                   pending;
int                   n_errors;
int                   n_failed;
int                   n_tests;
int                   mem_cycle = 0;

stim_row_t   rows [$];
logic [31:0] rd_addr_q [$];
tag_t        rd_id_q [$];
int          rd_due_q [$];

ro_stage_top #(.EDGE_BASE(EDGE_BASE)) u_ro_stage_top (
   .clk       (clk),
   .rstn      (rstn),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .in_task   (in_task),
   .arvalid   (arvalid),
   .arready   (arready),
   .araddr    (araddr),
   .arid      (arid),
   .rvalid    (rvalid),
   .rready    (rready),
   .rid       (rid),
   .rdata     (rdata),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_task  (out_task),
   .idle      (idle)
);

ro_stage_checker u_checker (
   .clk       (clk),
   .rstn      (rstn),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .in_task   (in_task),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_task  (out_task),
   .idle      (idle),
   .pending   (pending),
   .n_errors  (n_errors),
   .n_failed  (n_failed)
);

initial begin
   clk = 1'b0;
   forever #20 clk = ~clk;
end

task automatic add_row(input string name, input logic [31:0] ts, input logic [31:0] locale,
                       input int eo_begin, input int eo_end, input bit rnd, input bit last);
   stim_row_t r;
   r.name         = name;
   r.ts           = ts;
   r.locale       = locale;
   r.eo_begin     = 16'(eo_begin);
   r.eo_end       = 16'(eo_end);
   r.rnd_ready    = rnd;
   r.last_of_test = last;
   rows.push_back(r);
endtask

task automatic load_table();
   add_row("one_line", 32'd100, 32'd7, 2, 5, 1'b0, 1'b1);
   add_row("cross_line", 32'd1000, 32'd8, 13, 24, 1'b0, 1'b1);  // words 5..7, then a full line
   add_row("no_edges", 32'd2000, 32'd9, 30, 30, 1'b0, 1'b0);
   add_row("no_edges", 32'd2100, 32'd10, 40, 42, 1'b0, 1'b1);
   add_row("random_ready", 32'd3000, 32'd11, 50, 62, 1'b1, 1'b1);
   for (int i = 0; i < 10; i++) begin
      add_row("back_to_back", 32'(5000 + i * 16), 32'(200 + i), 100 + i * 6,
              100 + i * 6 + 1 + (i % 5), 1'b0, i == 9);
   end
endtask

function automatic int table_edges();
   int n;
   n = 0;
   foreach (rows[i]) n += int'(rows[i].eo_end) - int'(rows[i].eo_begin);
   return n;
endfunction

// word k of the line: index k + A/8 - base/8, weight 3*index+1 in [47:32]
function automatic logic [LINE_BITS-1:0] line_data(input logic [31:0] addr);
   logic [LINE_BITS-1:0] line;
   logic [31:0]          idx;
   line = '0;
   for (int k = 0; k < LINE_WORDS; k++) begin
      idx = 32'(k) + addr / 8 - EDGE_BASE / 8;
      line[k*64 +: 64] = {16'h0, 16'(idx * 3 + 1), idx};
   end
   return line;
endfunction

// memory model, in-order returns 1 to 6 cycles after the AR transfer
always @(posedge clk) begin
   mem_cycle++;
   arready <= ($urandom_range(3) != 0);
   if (!rstn) begin
      rvalid <= 1'b0;
   end else begin
      if (arvalid && arready) begin
         rd_addr_q.push_back(araddr);
         rd_id_q.push_back(arid);
         rd_due_q.push_back(mem_cycle + 1 + $urandom_range(5));
      end
      if (rvalid && rready) begin
         rvalid <= 1'b0;
         void'(rd_addr_q.pop_front());
         void'(rd_id_q.pop_front());
         void'(rd_due_q.pop_front());
      end else if (!rvalid && rd_addr_q.size() > 0 && mem_cycle >= rd_due_q[0]) begin
         rvalid <= 1'b1;
         rid    <= rd_id_q[0];
         rdata  <= line_data(rd_addr_q[0]);
      end
   end
end

always @(posedge clk) begin
   out_ready <= ready_mode ? 1'($urandom_range(1)) : 1'b1;
end

task automatic apply_row(input stim_row_t row);
   edge_task_t t;
   t.task_desc.ts     = row.ts;
   t.task_desc.locale = row.locale;
   t.eo_begin         = row.eo_begin;
   t.eo_end           = row.eo_end;
   in_valid   <= 1'b1;
   in_task    <= t;
   ready_mode <= row.rnd_ready;
   do @(negedge clk); while (!in_ready);
   @(posedge clk);  // transfer on this edge
   in_valid <= 1'b0;
endtask

task automatic wait_drain();
   @(negedge clk);
   while (pending != 0) @(negedge clk);
endtask

initial begin : watchdog
   int limit;
   int cycles;
   cycles = 0;
   @(posedge clk);
   limit = 200 + 12 * table_edges();
   while (cycles < limit) begin
      @(posedge clk);
      cycles++;
   end
   $display("timeout: the run did not finish within %0d cycles", limit);
   $display("Done: errors found");
   $finish;
end

initial begin : stimulus
   bit new_test;
   int assert_fails;
   void'($urandom(32'he32d));
   rstn       = 1'b0;
   in_valid   = 1'b0;
   in_task    = '0;
   arready    = 1'b0;
   rvalid     = 1'b0;
   rid        = '0;
   rdata      = '0;
   out_ready  = 1'b0;
   ready_mode = 1'b0;
   n_tests    = 0;
   load_table();
   repeat (2) @(posedge clk);
   rstn <= 1'b1;
   @(posedge clk);
   new_test = 1'b1;
   foreach (rows[i]) begin
      if (new_test) u_checker.start_test(rows[i].name);
      apply_row(rows[i]);
      new_test = rows[i].last_of_test;
      if (rows[i].last_of_test) begin
         wait_drain();
         u_checker.finish_test();
         n_tests++;
         @(posedge clk);
      end
   end
   repeat (20) @(negedge clk);  // catch stray children
   assert_fails = u_ro_stage_top.u_read_issuer.u_issuer_asserts.fail_count
                + u_ro_stage_top.u_line_unpacker.u_unpacker_asserts.fail_count;
   $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
            n_tests, n_failed, n_errors, assert_fails);
   if (n_failed == 0 && n_errors == 0 && assert_fails == 0) begin
      $display("Done: no errors");
   end else begin
      $display("Done: errors found");
   end
   $finish;
end

endmodule

/* tb.f */
common/sssp_pkg.sv
hw/free_list.sv
hw/edge_addr_gen.sv
hw/thread_ctrl.sv
read_engine/read_issuer.sv
read_engine/line_unpacker.sv
hw/child_gen.sv
hw/ro_stage_top.sv
test/ro_stage_asserts.sv
test/ro_stage_checker.sv
test/ro_stage_tb.sv

/* Bender.yml */
package:
  name: ro_stage

sources:
  - common/sssp_pkg.sv
  - hw/free_list.sv
  - hw/edge_addr_gen.sv
  - hw/thread_ctrl.sv
  - read_engine/read_issuer.sv
  - read_engine/line_unpacker.sv
  - hw/child_gen.sv
  - hw/ro_stage_top.sv
  - target: test
    files:
      - test/ro_stage_asserts.sv
      - test/ro_stage_checker.sv
      - test/ro_stage_tb.sv
